// File: ntm_pkg.sv
/*
 * Shared sizes, fixed-point constants and multiply rule,
 * opcode enum and host command/response structs
 */

`default_nettype none

package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Memory shape, N rows by W words
  localparam int MEM_ROWS = 4;
  localparam int MEM_COLS = 4;

  // Signed fixed point, Q7.8
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [DATA_WIDTH-1:0] word_t;

  // One memory row, also erase, add and read vectors
  typedef word_t [MEM_COLS-1:0] row_t;

  // Weighting, one word per row
  typedef word_t [MEM_ROWS-1:0] weight_t;

  typedef logic [$clog2(MEM_ROWS)-1:0] row_idx_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } opcode_e;

  // Host command, held stable while req is high
  typedef struct packed {
    opcode_e opcode;
    weight_t weight;
    row_t    erase;
    row_t    add;
  } head_cmd_t;

  // Last completed read vector
  typedef struct packed {
    row_t rd_vec;
  } head_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Fixed-point arithmetic
  //////////////////////////////////////////////////////////////////////

  localparam word_t ONE = word_t'(1 << FRAC_BITS);

  // Full-width product, arithmetic shift (floor), wrap to one word
  function automatic word_t fx_mul(word_t a, word_t b);
    logic signed [2*DATA_WIDTH-1:0] prod;
    prod = a * b;
    return word_t'(prod >>> FRAC_BITS);
  endfunction

endpackage

`default_nettype wire

// File: ntm_sequencer.sv
/*
 * Command FSM: req/ack handshake, row sweep control
 * for the counter, read accumulator and memory write
 */

`timescale 1ns/100ps
`default_nettype none

module ntm_sequencer (
  input  wire              CLK,
  input  wire              RST,
  input  wire              req,
  output logic             ack,
  input  ntm_pkg::opcode_e opcode,
  input  wire              last_row,
  output logic             count_clear,
  output logic             count_step,
  output logic             acc_clear,
  output logic             acc_step,
  output logic             row_we
);

  // IDLE -> SWEEP (N rows) -> ACK (one cycle) -> WAIT_LOW until req drops
  typedef enum logic [1:0] {
    IDLE,
    SWEEP,
    ACK,
    WAIT_LOW
  } state_e;

  state_e state_q;
  state_e state_d;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req) begin
          state_d = SWEEP;
        end
      end
      // Last row processed on this edge
      SWEEP: begin
        if (last_row) begin
          state_d = ACK;
        end
      end
      // Read result lands in rsp during this cycle
      ACK: begin
        state_d = WAIT_LOW;
      end
      // Back-pressure, hold ack while host keeps req
      WAIT_LOW: begin
        if (!req) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs, decoded from state
  //////////////////////////////////////////////////////////////////////

  // Start of command, reset row index and working sum
  assign count_clear = (state_q == IDLE) && req;
  assign acc_clear   = (state_q == IDLE) && req;

  // One row per cycle during the sweep
  assign count_step = (state_q == SWEEP);
  assign acc_step   = (state_q == SWEEP) && (opcode == ntm_pkg::OP_READ);
  assign row_we     = (state_q == SWEEP) && (opcode == ntm_pkg::OP_WRITE);

  assign ack = (state_q == WAIT_LOW);

endmodule

`default_nettype wire

// File: ntm_row_counter.sv
/*
 * Row index counter for the memory sweep with last-row flag
 */

`timescale 1ns/100ps
`default_nettype none

module ntm_row_counter (
  input  wire               CLK,
  input  wire               RST,
  input  wire               count_clear,
  input  wire               count_step,
  output ntm_pkg::row_idx_t row_idx,
  output logic              last_row
);

  // Clear wins over step
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_idx <= '0;
    end else if (count_clear) begin
      row_idx <= '0;
    end else if (count_step) begin
      // Wraps back to row 0 after the final row
      row_idx <= row_idx + 1'b1;
    end
  end

  // Final row of the sweep
  assign last_row = (row_idx == ntm_pkg::row_idx_t'(ntm_pkg::MEM_ROWS - 1));

endmodule

`default_nettype wire

// File: ntm_memory.sv
/*
 * Memory matrix as register rows,
 * combinational row read, clocked row write
 */

`timescale 1ns/100ps
`default_nettype none

module ntm_memory (
  input  wire               CLK,
  input  wire               RST,
  input  ntm_pkg::row_idx_t row_idx,
  input  wire               row_we,
  input  ntm_pkg::row_t     new_row,
  output ntm_pkg::row_t     rd_row
);

  // N rows of W words
  ntm_pkg::row_t mem_q [ntm_pkg::MEM_ROWS];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // All rows zero after reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int j = 0; j < ntm_pkg::MEM_ROWS; j++) begin
        mem_q[j] <= '0;
      end
    end else if (row_we) begin
      // Updated row from the write head
      mem_q[row_idx] <= new_row;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Addressed row, zero latency
  assign rd_row = mem_q[row_idx];

endmodule

`default_nettype wire

// File: ntm_read_head.sv
/*
 * Read head: accumulates w(j)*M(j;k) over the rows,
 * registers the completed vector as the response
 */

`timescale 1ns/100ps
`default_nettype none

module ntm_read_head (
  input  wire                CLK,
  input  wire                RST,
  input  wire                acc_clear,
  input  wire                acc_step,
  input  ntm_pkg::row_idx_t  row_idx,
  input  ntm_pkg::weight_t   weight,
  input  ntm_pkg::row_t      rd_row,
  output ntm_pkg::head_rsp_t rsp
);

  // Working sums, one per column
  ntm_pkg::row_t acc_q;
  ntm_pkg::row_t acc_d;
  ntm_pkg::word_t w_row;
  logic          at_wrap;

  // Weight of the row being swept
  assign w_row = weight[row_idx];

  // Counter sits on its top index, next step wraps
  assign at_wrap = (row_idx == ntm_pkg::row_idx_t'(ntm_pkg::MEM_ROWS - 1));

  //////////////////////////////////////////////////////////////////////
  // Column accumulate
  //////////////////////////////////////////////////////////////////////

  // Sum wraps to one word
  always_comb begin
    for (int k = 0; k < ntm_pkg::MEM_COLS; k++) begin
      acc_d[k] = acc_q[k] + ntm_pkg::fx_mul(w_row, rd_row[k]);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_q <= '0;
    end else if (acc_clear) begin
      acc_q <= '0;
    end else if (acc_step) begin
      acc_q <= acc_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////////////////////////

  // Copy out only when the final row has been added
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rsp <= '0;
    end else if (acc_step && at_wrap) begin
      rsp.rd_vec <= acc_d;
    end
  end

endmodule

`default_nettype wire

// File: ntm_write_head.sv
/*
 * Write head: erase then add on the addressed row,
 * M*(1 - w*e) + w*a per column, combinational
 */

`timescale 1ns/100ps
`default_nettype none

module ntm_write_head (
  input  ntm_pkg::row_idx_t row_idx,
  input  ntm_pkg::weight_t  weight,
  input  ntm_pkg::row_t     erase,
  input  ntm_pkg::row_t     add,
  input  ntm_pkg::row_t     rd_row,
  output ntm_pkg::row_t     new_row
);

  ntm_pkg::word_t w_row;

  // Keep factor per column, 1 - w(j)*e(k)
  ntm_pkg::row_t keep;

  // Weight of the addressed row
  assign w_row = weight[row_idx];

  //////////////////////////////////////////////////////////////////////
  // Erase and add
  //////////////////////////////////////////////////////////////////////

  // Each product truncated and wrapped on its own
  always_comb begin
    for (int k = 0; k < ntm_pkg::MEM_COLS; k++) begin
      keep[k]    = ntm_pkg::ONE - ntm_pkg::fx_mul(w_row, erase[k]);
      // w = 0 leaves the row as is, w = e = ONE loads a(k)
      new_row[k] = ntm_pkg::fx_mul(rd_row[k], keep[k])
                 + ntm_pkg::fx_mul(w_row, add[k]);
    end
  end

endmodule

`default_nettype wire

// File: ntm_heads_top.sv
/*
 * NTM memory unit top: sequencer, row counter,
 * memory matrix, read head and write head
 */

`timescale 1ns/100ps
`default_nettype none

module ntm_heads_top (
  input  wire                CLK,
  input  wire                RST,
  input  wire                req,
  output logic               ack,
  input  ntm_pkg::head_cmd_t cmd,
  output ntm_pkg::head_rsp_t rsp
);

  // Sequencer controls
  logic count_clear;
  logic count_step;
  logic acc_clear;
  logic acc_step;
  logic row_we;

  // Counter outputs
  ntm_pkg::row_idx_t row_idx;
  logic              last_row;

  // Row data
  ntm_pkg::row_t rd_row;
  ntm_pkg::row_t new_row;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  ntm_sequencer u_seq (
    .CLK         (CLK),
    .RST         (RST),
    .req         (req),
    .ack         (ack),
    .opcode      (cmd.opcode),
    .last_row    (last_row),
    .count_clear (count_clear),
    .count_step  (count_step),
    .acc_clear   (acc_clear),
    .acc_step    (acc_step),
    .row_we      (row_we)
  );

  ntm_row_counter u_cnt (
    .CLK         (CLK),
    .RST         (RST),
    .count_clear (count_clear),
    .count_step  (count_step),
    .row_idx     (row_idx),
    .last_row    (last_row)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  ntm_memory u_mem (
    .CLK     (CLK),
    .RST     (RST),
    .row_idx (row_idx),
    .row_we  (row_we),
    .new_row (new_row),
    .rd_row  (rd_row)
  );

  ntm_read_head u_rd (
    .CLK       (CLK),
    .RST       (RST),
    .acc_clear (acc_clear),
    .acc_step  (acc_step),
    .row_idx   (row_idx),
    .weight    (cmd.weight),
    .rd_row    (rd_row),
    .rsp       (rsp)
  );

  // Feeds back into the memory write port
  ntm_write_head u_wr (
    .row_idx (row_idx),
    .weight  (cmd.weight),
    .erase   (cmd.erase),
    .add     (cmd.add),
    .rd_row  (rd_row),
    .new_row (new_row)
  );

endmodule

`default_nettype wire

// File: ntm_heads_asserts.sv
/*
 * Concurrent checks on the req/ack handshake
 * and on ack during reset
 */

`timescale 1ns/100ps
`default_nettype none

module ntm_heads_asserts (
  input wire CLK,
  input wire RST,
  input wire req,
  input wire ack
);

  // Number of failed checks
  int unsigned fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // ack only ever rises on an edge that saw the host holding req
  ack_needs_req: assert property (@(posedge CLK) disable iff (RST)
    $rose(ack) |-> $past(req))
  else begin
    $error("ack rose without req");
    fail_count++;
  end

  // Back-pressure holds ack as long as req
  ack_held: assert property (@(posedge CLK) disable iff (RST)
    (ack && req) |=> ack)
  else begin
    $error("ack dropped while req was still high");
    fail_count++;
  end

  // ack falls one cycle after req is seen low
  ack_release: assert property (@(posedge CLK) disable iff (RST)
    (ack && !req) |=> !ack)
  else begin
    $error("ack did not fall after req fell");
    fail_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////////////////////////

  ack_low_in_reset: assert property (@(posedge CLK) RST |-> !ack)
  else begin
    $error("ack high during reset");
    fail_count++;
  end

endmodule

`default_nettype wire

// File: tb_ntm_heads.sv
/*
 * Testbench for the NTM memory unit with clock, reset, host handshake,
 * reference memory model and value checks
 */

`timescale 1ns/100ps
`default_nettype none

module tb_ntm_heads;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int RANDOM_CMDS    = 40;

  logic               CLK;
  logic               RST;
  logic               req;
  logic               ack;
  ntm_pkg::head_cmd_t cmd;
  ntm_pkg::head_rsp_t rsp;

  // Reference copy of the memory matrix
  ntm_pkg::word_t model_mem [ntm_pkg::MEM_ROWS][ntm_pkg::MEM_COLS];

  ntm_heads_top DUT (
    .CLK (CLK),
    .RST (RST),
    .req (req),
    .ack (ack),
    .cmd (cmd),
    .rsp (rsp)
  );

  bind ntm_heads_top ntm_heads_asserts u_asserts (
    .CLK (CLK),
    .RST (RST),
    .req (req),
    .ack (ack)
  );

  // 100 ns period
  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  // Stop at the first handshake assertion failure
  always @(DUT.u_asserts.fail_count) begin
    if (DUT.u_asserts.fail_count != 0) begin
      $display("Handshake assertion failed at time %0t", $time);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Sign-extend, full product, drop FRAC_BITS (floor), keep one word
  function automatic ntm_pkg::word_t fixed_mul(ntm_pkg::word_t a, ntm_pkg::word_t b);
    logic [2*ntm_pkg::DATA_WIDTH-1:0] full;
    full = {{ntm_pkg::DATA_WIDTH{a[ntm_pkg::DATA_WIDTH-1]}}, a}
         * {{ntm_pkg::DATA_WIDTH{b[ntm_pkg::DATA_WIDTH-1]}}, b};
    return full[ntm_pkg::FRAC_BITS +: ntm_pkg::DATA_WIDTH];
  endfunction

  // r(k) = sum_j w(j)*M(j;k)
  function automatic ntm_pkg::row_t model_read(ntm_pkg::weight_t w);
    ntm_pkg::row_t r;
    r = '0;
    for (int k = 0; k < ntm_pkg::MEM_COLS; k++) begin
      for (int j = 0; j < ntm_pkg::MEM_ROWS; j++) begin
        r[k] = r[k] + fixed_mul(w[j], model_mem[j][k]);
      end
    end
    return r;
  endfunction

  // Erase then add on every row
  task automatic model_write(ntm_pkg::weight_t w, ntm_pkg::row_t e, ntm_pkg::row_t a);
    ntm_pkg::word_t keep;
    for (int j = 0; j < ntm_pkg::MEM_ROWS; j++) begin
      for (int k = 0; k < ntm_pkg::MEM_COLS; k++) begin
        keep = ntm_pkg::word_t'(256) - fixed_mul(w[j], e[k]);
        model_mem[j][k] = fixed_mul(model_mem[j][k], keep) + fixed_mul(w[j], a[k]);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // Polls ack once per cycle just after the edge
  task automatic wait_ack(logic level, string name);
    int cycles;
    cycles = 0;
    while (ack !== level) begin
      @(posedge CLK);
      #1;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout in %s: ack never went to %0b", name, level);
        $display("*** TEST FAILED ***");
        $fatal(1);
      end
    end
  endtask

  // Full four-phase command with hold cycles of extra back-pressure
  task automatic run_command(ntm_pkg::opcode_e op, ntm_pkg::weight_t w, ntm_pkg::row_t e,
                             ntm_pkg::row_t a, int hold, string name);
    ntm_pkg::row_t  expected;
    ntm_pkg::head_rsp_t rsp_before;
    rsp_before = rsp;
    cmd.opcode = op;
    cmd.weight = w;
    cmd.erase  = e;
    cmd.add    = a;
    req        = 1'b1;
    wait_ack(1'b1, name);
    if (op == ntm_pkg::OP_READ) begin
      expected = model_read(w);
    end else begin
      model_write(w, e, a);
      // Write leaves the last read result alone
      expected = rsp_before.rd_vec;
    end
    check_value(name, expected, rsp.rd_vec);
    repeat (hold) begin
      @(posedge CLK);
      #1;
      check_value({name, " ack hold"}, 64'd1, 64'(ack));
      check_value({name, " rsp hold"}, expected, rsp.rd_vec);
    end
    req = 1'b0;
    wait_ack(1'b0, name);
  endtask

  function automatic ntm_pkg::weight_t one_hot(int row);
    ntm_pkg::weight_t w;
    w      = '0;
    w[row] = ntm_pkg::word_t'(256);
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    ntm_pkg::weight_t w;
    ntm_pkg::row_t    e;
    ntm_pkg::row_t    a;
    ntm_pkg::row_t    all_one;
    ntm_pkg::opcode_e op;
    void'($urandom(63681));
    RST = 1'b1;
    req = 1'b0;
    cmd = '0;
    for (int j = 0; j < ntm_pkg::MEM_ROWS; j++) begin
      for (int k = 0; k < ntm_pkg::MEM_COLS; k++) begin
        model_mem[j][k] = '0;
      end
    end
    for (int k = 0; k < ntm_pkg::MEM_COLS; k++) begin
      all_one[k] = ntm_pkg::word_t'(256);
    end
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Memory and ack clear after reset
    check_value("reset ack", 64'd0, 64'(ack));
    for (int j = 0; j < ntm_pkg::MEM_ROWS; j++) begin
      run_command(ntm_pkg::OP_READ, one_hot(j), '0, '0, 0, "reset read");
    end

    // Row loads read back exactly
    for (int j = 0; j < ntm_pkg::MEM_ROWS; j++) begin
      a = {$urandom, $urandom};
      run_command(ntm_pkg::OP_WRITE, one_hot(j), all_one, a, 1, "row load");
      run_command(ntm_pkg::OP_READ, one_hot(j), '0, '0, 0, "row readback");
      check_value("row load exact", a, rsp.rd_vec);
    end

    // 0.5 on rows 0 and 2
    w    = '0;
    w[0] = 16'sh0080;
    w[2] = 16'sh0080;
    run_command(ntm_pkg::OP_READ, w, '0, '0, 2, "blended read");

    // Fractional writes and reads with random back-pressure
    for (int n = 0; n < RANDOM_CMDS; n++) begin
      op = ($urandom_range(0, 1) == 1) ? ntm_pkg::OP_WRITE : ntm_pkg::OP_READ;
      for (int j = 0; j < ntm_pkg::MEM_ROWS; j++) begin
        w[j] = ntm_pkg::word_t'($urandom_range(0, 256));
      end
      for (int k = 0; k < ntm_pkg::MEM_COLS; k++) begin
        e[k] = ntm_pkg::word_t'($urandom_range(0, 256));
        a[k] = ntm_pkg::word_t'($urandom);
      end
      run_command(op, w, e, a, $urandom_range(0, 5), "random command");
    end

    repeat (3) @(posedge CLK);
    #1;
    if (DUT.u_asserts.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("Handshake assertions failed %0d times", DUT.u_asserts.fail_count);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: compile.f
ntm_pkg.sv
ntm_sequencer.sv
ntm_row_counter.sv
ntm_memory.sv
ntm_read_head.sv
ntm_write_head.sv
ntm_heads_top.sv
ntm_heads_asserts.sv
tb_ntm_heads.sv

// File: Bender.yml
package:
  name: ntm_heads

sources:
  - ntm_pkg.sv
  - ntm_sequencer.sv
  - ntm_row_counter.sv
  - ntm_memory.sv
  - ntm_read_head.sv
  - ntm_write_head.sv
  - ntm_heads_top.sv
  - target: test
    files:
      - ntm_heads_asserts.sv
      - tb_ntm_heads.sv
